// File: rtl/uart_fifo.sv
`timescale 1ns/1ps

module uart_fifo #(
	parameter int width      = 8,
	parameter int fifo_depth = 4
) (
	input  logic             clk,
	input  logic             rst,
	input  logic [width-1:0] in_data,
	input  logic             in_valid,
	output logic             in_ready,
	output logic [width-1:0] out_data,
	output logic             out_valid,
	input  logic             out_ready
);

	localparam int addr_w = $clog2(fifo_depth);

	logic [width-1:0] mem [fifo_depth];
	// one extra bit tells full from empty
	logic [addr_w:0]  wr_ptr;
	logic [addr_w:0]  rd_ptr;
	logic             full;
	logic             empty;
	logic             do_wr;
	logic             do_rd;

	assign empty = (wr_ptr == rd_ptr);
	// same slot, different lap
	assign full  = (wr_ptr == {~rd_ptr[addr_w], rd_ptr[addr_w-1:0]});

	assign out_valid = !empty;
	assign out_data  = mem[rd_ptr[addr_w-1:0]];
	// a read in this cycle frees a slot for the write
	assign in_ready  = !full || out_ready;

	assign do_wr = in_valid && in_ready;
	assign do_rd = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr[addr_w-1:0]] <= in_data;
		end
	end

endmodule

// File: rtl/uart_pkg.sv
package uart_pkg;

	// one data byte as it travels on the serial line
	typedef logic [7:0] uart_byte_t;

	// received byte plus its framing status
	// frame_err is set when the stop bit was sampled low
	typedef struct packed {
		uart_byte_t data;
		logic       frame_err;
	} rx_word_t;

	// receiver FSM
	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	// transmitter FSM
	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop
	} tx_state_t;

endpackage

// File: rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
	parameter int clk_div = 16
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              rxi,
	output uart_pkg::rx_word_t word,
	output logic              word_strobe
);

	localparam int cnt_w = $clog2(clk_div);
	// cycle index of the last cycle in one bit period
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clk_div - 1);
	// cycle index of the half-bit point, counted from the falling edge
	localparam logic [cnt_w-1:0] cnt_half = cnt_w'(clk_div / 2 - 1);
	// cycle index of the last stop-bit cycle, counted after the stop sample
	localparam logic [cnt_w-1:0] cnt_rest = cnt_w'(clk_div - clk_div / 2 - 2);

	uart_pkg::rx_state_t state;
	logic [1:0]          sync_q;
	logic                line_d;
	logic                line;
	logic [cnt_w-1:0]    cnt;
	logic [2:0]          bit_idx;
	logic                stop_seen;
	logic                sample_data;
	logic                sample_stop;

	// two flop synchronizer, idles high like the line
	always_ff @(posedge clk) begin
		if (rst) begin
			sync_q <= 2'b11;
			line_d <= 1'b1;
		end else begin
			sync_q <= {sync_q[0], rxi};
			line_d <= sync_q[1];
		end
	end

	assign line = sync_q[1];

	// after the start bit the counter is aligned to mid-bit,
	// so every wrap of the counter is a sample point
	assign sample_data = (state == uart_pkg::rx_data) && (cnt == cnt_last);
	assign sample_stop = (state == uart_pkg::rx_stop) && !stop_seen && (cnt == cnt_last);

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= uart_pkg::rx_idle;
			cnt         <= '0;
			bit_idx     <= '0;
			stop_seen   <= 1'b0;
			word_strobe <= 1'b0;
		end else begin
			word_strobe <= 1'b0;
			cnt         <= cnt + 1'b1;
			case (state)
				uart_pkg::rx_idle: begin
					cnt <= '0;
					// falling edge on the synchronized line
					if (line_d && !line) begin
						state <= uart_pkg::rx_start;
					end
				end
				uart_pkg::rx_start: begin
					if (line) begin
						// line came back before half a bit, treat as a glitch
						state <= uart_pkg::rx_idle;
					end else if (cnt == cnt_half) begin
						// start bit confirmed at its middle
						state   <= uart_pkg::rx_data;
						cnt     <= '0;
						bit_idx <= '0;
					end
				end
				uart_pkg::rx_data: begin
					if (sample_data) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state     <= uart_pkg::rx_stop;
							stop_seen <= 1'b0;
						end
					end
				end
				uart_pkg::rx_stop: begin
					if (sample_stop) begin
						// word goes out even with a bad stop bit
						word_strobe <= 1'b1;
						stop_seen   <= 1'b1;
						cnt         <= '0;
					end else if (stop_seen && cnt == cnt_rest) begin
						// rest of the stop bit is over, idle sees the next edge
						state     <= uart_pkg::rx_idle;
						stop_seen <= 1'b0;
					end
				end
				default: state <= uart_pkg::rx_idle;
			endcase
		end
	end

	// payload, lsb first into the top of the shift register
	always_ff @(posedge clk) begin
		if (sample_data) begin
			word.data <= {line, word.data[7:1]};
		end
		if (sample_stop) begin
			word.frame_err <= !line;
		end
	end

endmodule

// File: rtl/uart_top.sv
`timescale 1ns/1ps

module uart_top #(
	parameter int clk_div    = 16,
	parameter int fifo_depth = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  uart_pkg::uart_byte_t tx_data,
	input  logic                tx_valid,
	output logic                tx_ready,
	output uart_pkg::rx_word_t   rx_word,
	output logic                rx_valid,
	input  logic                rx_ready,
	output logic                txo,
	input  logic                rxi,
	output logic                rx_overrun
);

	localparam int rx_w = $bits(uart_pkg::rx_word_t);

	// transmit FIFO to transmitter
	uart_pkg::uart_byte_t tx_byte;
	logic                 tx_byte_valid;
	logic                 tx_byte_ready;

	// receiver to receive FIFO
	uart_pkg::rx_word_t rx_new_word;
	logic               rx_strobe;
	logic               rx_fifo_ready;

	uart_fifo #(
		.width(8),
		.fifo_depth(fifo_depth)
	) u_tx_fifo (
		.clk(clk),
		.rst(rst),
		.in_data(tx_data),
		.in_valid(tx_valid),
		.in_ready(tx_ready),
		.out_data(tx_byte),
		.out_valid(tx_byte_valid),
		.out_ready(tx_byte_ready)
	);

	uart_tx #(
		.clk_div(clk_div)
	) u_tx (
		.clk(clk),
		.rst(rst),
		.data(tx_byte),
		.valid(tx_byte_valid),
		.ready(tx_byte_ready),
		.txo(txo)
	);

	uart_rx #(
		.clk_div(clk_div)
	) u_rx (
		.clk(clk),
		.rst(rst),
		.rxi(rxi),
		.word(rx_new_word),
		.word_strobe(rx_strobe)
	);

	// the line cannot be stalled, the strobe is the write valid
	uart_fifo #(
		.width(rx_w),
		.fifo_depth(fifo_depth)
	) u_rx_fifo (
		.clk(clk),
		.rst(rst),
		.in_data(rx_new_word),
		.in_valid(rx_strobe),
		.in_ready(rx_fifo_ready),
		.out_data(rx_word),
		.out_valid(rx_valid),
		.out_ready(rx_ready)
	);

	// sticky until reset, a word arrived with nowhere to go
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_overrun <= 1'b0;
		end else if (rx_strobe && !rx_fifo_ready) begin
			rx_overrun <= 1'b1;
		end
	end

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
	parameter int clk_div = 16
) (
	input  logic                clk,
	input  logic                rst,
	input  uart_pkg::uart_byte_t data,
	input  logic                valid,
	output logic                ready,
	output logic                txo
);

	localparam int cnt_w = $clog2(clk_div);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clk_div - 1);

	uart_pkg::tx_state_t  state;
	uart_pkg::uart_byte_t shreg;
	logic [cnt_w-1:0]     cnt;
	logic [2:0]           bit_idx;
	logic                 bit_end;
	logic                 load;
	logic                 shift;

	assign bit_end = (cnt == cnt_last);

	// last stop cycle counts as idle, so frames can follow without a gap
	assign ready = (state == uart_pkg::tx_idle) ||
		((state == uart_pkg::tx_stop) && bit_end);
	assign load  = valid && ready;
	// shift out the next data bit at the end of start and of bits 0..6
	assign shift = bit_end && ((state == uart_pkg::tx_start) ||
		((state == uart_pkg::tx_data) && (bit_idx != 3'd7)));

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= uart_pkg::tx_idle;
			cnt     <= '0;
			bit_idx <= '0;
			txo     <= 1'b1;
		end else begin
			cnt <= bit_end ? '0 : cnt + 1'b1;
			if (load) begin
				// start bit begins on the next cycle
				state <= uart_pkg::tx_start;
				cnt   <= '0;
				txo   <= 1'b0;
			end else begin
				case (state)
					uart_pkg::tx_idle: begin
						cnt <= '0;
						txo <= 1'b1;
					end
					uart_pkg::tx_start: begin
						if (bit_end) begin
							state   <= uart_pkg::tx_data;
							bit_idx <= '0;
							txo     <= shreg[0];
						end
					end
					uart_pkg::tx_data: begin
						if (bit_end) begin
							bit_idx <= bit_idx + 1'b1;
							if (bit_idx == 3'd7) begin
								state <= uart_pkg::tx_stop;
								txo   <= 1'b1;
							end else begin
								txo <= shreg[0];
							end
						end
					end
					uart_pkg::tx_stop: begin
						if (bit_end) begin
							state <= uart_pkg::tx_idle;
						end
					end
					default: state <= uart_pkg::tx_idle;
				endcase
			end
		end
	end

	// data byte, bit 0 always next on the line
	always_ff @(posedge clk) begin
		if (load) begin
			shreg <= data;
		end else if (shift) begin
			shreg <= {1'b0, shreg[7:1]};
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the UART testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_uart -f src.f -o sim_tb_uart
./obj_dir/sim_tb_uart > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
	echo "result: fail"
	exit 1
fi
echo "result: pass"
exit 0

// File: src.f
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
verif/tb_uart.sv

// File: verif/tb_uart.sv
`timescale 1ns/1ps

module tb_uart;

	localparam int clk_div    = 8;
	localparam int fifo_depth = 4;
	// 40 loopback frames, 2 framing, 2 glitch, fifo_depth + 2 overrun
	localparam int n_frames       = 40 + 2 + 2 + fifo_depth + 2;
	localparam int timeout_cycles = n_frames * 12 * clk_div + 2000;

	logic                 clk;
	logic                 rst;
	uart_pkg::uart_byte_t tx_data;
	logic                 tx_valid;
	logic                 tx_ready;
	uart_pkg::rx_word_t   rx_word;
	logic                 rx_valid;
	logic                 rx_ready;
	logic                 txo;
	logic                 rxi;
	logic                 rx_overrun;

	// 1 routes txo back to rxi, 0 hands rxi to the line model
	logic        loopback;
	logic        line_q;
	// rx_ready mode, 0 held low, 1 held high, 2 random
	logic [1:0]  rx_mode;
	// rx_ready level chosen at the edge, driven just after it
	logic        rdy_next;
	logic [31:0] rng;
	int          errors;

	// words the receive side should deliver, in order
	uart_pkg::rx_word_t exp_q[$];

	uart_top #(
		.clk_div(clk_div),
		.fifo_depth(fifo_depth)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.rx_word(rx_word),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.txo(txo),
		.rxi(rxi),
		.rx_overrun(rx_overrun)
	);

	assign rxi = loopback ? txo : line_q;

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	// n rising edges, then the drive point just after the last one
	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#0.5;
	endtask

	task automatic expect_word(input uart_pkg::uart_byte_t data, input logic ferr);
		uart_pkg::rx_word_t w;
		w.data      = data;
		w.frame_err = ferr;
		exp_q.push_back(w);
	endtask

	// hold tx_valid until the transmit FIFO takes the byte
	task automatic offer_byte(input uart_pkg::uart_byte_t b);
		tx_data  = b;
		tx_valid = 1'b1;
		@(negedge clk);
		while (!tx_ready) begin
			@(negedge clk);
		end
		step(1);
		tx_valid = 1'b0;
		expect_word(b, 1'b0);
	endtask

	task automatic line_bit(input logic level);
		line_q = level;
		step(clk_div);
	endtask

	// start bit, data lsb first, chosen stop level, two idle bits
	task automatic line_frame(input uart_pkg::uart_byte_t data, input logic stop_level);
		line_bit(1'b0);
		for (int i = 0; i < 8; i++) begin
			line_bit(data[i]);
		end
		line_bit(stop_level);
		line_q = 1'b1;
		step(2 * clk_div);
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		step(4);
	endtask

	// rx_ready is picked at the edge and changes just after it
	always @(posedge clk) begin
		case (rx_mode)
			2'd0: rdy_next = 1'b0;
			2'd1: rdy_next = 1'b1;
			default: rdy_next = (next_rand() % 4) != 0;
		endcase
		#0.5;
		rx_ready = rdy_next;
	end

	// a transfer seen at the falling edge happens at the next rising edge
	always @(negedge clk) begin
		if (!rst && rx_valid && rx_ready) begin
			if (exp_q.size() == 0) begin
				$display("received word 0x%0h that was never sent", rx_word);
				errors++;
			end else begin
				check_equal("rx_word", {23'b0, rx_word}, {23'b0, exp_q.pop_front()});
			end
		end
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("run timed out after %0d cycles, a handshake never completed",
			timeout_cycles);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		clk      = 1'b0;
		rst      = 1'b1;
		tx_data  = '0;
		tx_valid = 1'b0;
		rx_ready = 1'b0;
		line_q   = 1'b1;
		loopback = 1'b0;
		rx_mode  = 2'd0;
		rng      = 32'd71004;
		errors   = 0;
		step(2);
		rst = 1'b0;

		// reset values
		@(negedge clk);
		check_equal("txo", {31'b0, txo}, 32'd1);
		check_equal("tx_ready", {31'b0, tx_ready}, 32'd1);
		check_equal("rx_valid", {31'b0, rx_valid}, 32'd0);
		check_equal("rx_overrun", {31'b0, rx_overrun}, 32'd0);
		step(1);

		// loopback with random gaps and a throttled reader
		loopback = 1'b1;
		rx_mode  = 2'd2;
		for (int n = 0; n < 40; n++) begin
			r = next_rand();
			step(1 + int'(r % 8));
			r = next_rand();
			offer_byte(r[7:0]);
		end
		wait_drain();
		rx_mode = 2'd1;
		step(2 * clk_div);
		check_equal("rx_overrun", {31'b0, rx_overrun}, 32'd0);
		loopback = 1'b0;
		step(2);

		// low stop bit, then a clean frame
		expect_word(8'ha5, 1'b1);
		line_frame(8'ha5, 1'b0);
		expect_word(8'h3c, 1'b0);
		line_frame(8'h3c, 1'b1);
		wait_drain();

		// short low pulse must not start a frame
		// wait longer than a whole frame so a false start would deliver a word
		line_q = 1'b0;
		step(2);
		line_q = 1'b1;
		step(12 * clk_div);
		check_equal("rx_valid", {31'b0, rx_valid}, 32'd0);
		r = next_rand();
		expect_word(r[7:0], 1'b0);
		line_frame(r[7:0], 1'b1);
		wait_drain();

		// reader stalled, last two frames overflow the receive FIFO
		rx_mode = 2'd0;
		step(2);
		for (int n = 0; n < fifo_depth + 2; n++) begin
			r = next_rand();
			if (n < fifo_depth) begin
				expect_word(r[7:0], 1'b0);
			end
			line_frame(r[7:0], 1'b1);
		end
		check_equal("rx_overrun", {31'b0, rx_overrun}, 32'd1);
		rx_mode = 2'd1;
		wait_drain();
		step(clk_div);
		check_equal("rx_valid", {31'b0, rx_valid}, 32'd0);

		$display("checks done, %0d errors", errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
